// ==== dma_engine.f ====
+incdir+rtl
rtl/emesh_pkg.sv
rtl/dma_pkg.sv
rtl/emesh_decode.sv
rtl/emesh_encode.sv
rtl/dma_datapath.sv
rtl/dma_seq.sv
rtl/dma_engine.sv
tb/tb_dma_engine.sv

// ==== rtl/dma_cfg.svh ====
// dma configuration macros for address, packet and count widths
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// ################################################
// widths
// ################################################

`define DMA_AW 32                // address and data word

// mesh packet, head of 40 bits plus two words
`define DMA_PW (2*`DMA_AW+40)

`define DMA_CW 16                // one half of the 2d count

`endif

// ==== rtl/dma_datapath.sv ====
// dma datapath, steps count and addresses, muxes packet fields, registers output
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_datapath
   import dma_pkg::*;
   import emesh_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               arst_n,
   input  wire logic               master_mode,
   input  wire logic [1:0]         datamode,
   input  wire logic [4:0]         ctrlmode,
   input  wire logic [31:0]        stride,
   input  wire logic               update2d,
   input  wire logic               beat,
   input  wire dma_half_t          inner_start,
   input  wire dma_count_t         count_reg,
   input  wire logic [`DMA_AW-1:0] srcaddr_reg,
   input  wire logic [`DMA_AW-1:0] dstaddr_reg,
   input  wire dma_state_e         state,
   input  wire logic               write_in,
   input  wire logic [1:0]         datamode_in,
   input  wire logic [4:0]         ctrlmode_in,
   input  wire logic [`DMA_AW-1:0] dstaddr_in,
   input  wire emesh_payload_u     payload_in,
   input  wire logic               wait_in,
   output dma_count_t              count_next,
   output logic [`DMA_AW-1:0]      srcaddr_next,
   output logic [`DMA_AW-1:0]      dstaddr_next,
   output logic                    write_out,
   output logic [1:0]              datamode_out,
   output logic [4:0]              ctrlmode_out,
   output logic [`DMA_AW-1:0]      dstaddr_out,
   output emesh_payload_u          payload_out,
   input  wire logic [`DMA_PW-1:0] packet,
   output logic                    access_out,
   output logic [`DMA_PW-1:0]      packet_out,
   output logic                    wait_out
);

   // ################################################
   // count and address stepping
   // ################################################

   always_comb begin
      if (update2d) begin                   // inner wrapped, step outer
         count_next.outer = count_reg.outer - 1'b1;
         count_next.inner = inner_start;
      end else begin
         count_next.outer = count_reg.outer;
         count_next.inner = count_reg.inner - 1'b1;
      end
   end

   // signed 16 bit steps, src low half, dst high half
   assign srcaddr_next = srcaddr_reg + {{(`DMA_AW-16){stride[15]}}, stride[15:0]};
   assign dstaddr_next = dstaddr_reg + {{(`DMA_AW-16){stride[31]}}, stride[31:16]};

   // ################################################
   // master/slave field mux
   // ################################################

   assign write_out    = master_mode ? 1'b0     : write_in;     // master sends reads
   assign datamode_out = master_mode ? datamode : datamode_in;
   assign ctrlmode_out = master_mode ? ctrlmode : ctrlmode_in;

   // sequenced address on every beat
   // slave head passes unchanged otherwise, never launched then
   assign dstaddr_out = (master_mode || beat) ? dstaddr_reg : dstaddr_in;

   always_comb begin
      if (master_mode) begin
         payload_out.rd.retaddr = srcaddr_reg;   // read data comes back here
         payload_out.rd.rsvd    = '0;
      end else begin
         payload_out.wr = payload_in.wr;         // write data untouched
      end
   end

   // ################################################
   // output register
   // ################################################

   always_ff @(posedge clk) begin
      if (!wait_in) packet_out <= packet;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         access_out <= 1'b0;
      end else if (!wait_in) begin
         access_out <= beat;                     // one packet per accepted beat
      end
   end

   assign wait_out = wait_in;                    // slave stream sees the same pushback

   // output frozen for a cycle of pushback
   a_hold_on_wait: assert property (
      @(posedge clk) disable iff (!arst_n)
      $past(wait_in) |-> ($stable(packet_out) && $stable(access_out)));

   // a fresh access only ever comes from a running sequencer
   a_access_from_run: assert property (
      @(posedge clk) disable iff (!arst_n)
      $rose(access_out) |-> $past(state == ST_RUN));

endmodule

`default_nettype wire

// ==== rtl/dma_engine.sv ====
// dma engine top, sequencer and datapath around the mesh packet codec
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_engine
   import dma_pkg::*;
   import emesh_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               arst_n,
   // configuration
   input  wire logic               start,
   input  wire logic               master_mode,
   input  wire logic [1:0]         datamode,
   input  wire logic [4:0]         ctrlmode,
   input  wire logic [31:0]        stride,
   input  wire dma_count_t         count,
   input  wire logic [`DMA_AW-1:0] srcaddr,
   input  wire logic [`DMA_AW-1:0] dstaddr,
   output logic                    busy,
   output logic                    done,
   // slave stream in
   input  wire logic               access_in,
   input  wire logic [`DMA_PW-1:0] packet_in,
   output logic                    wait_out,
   // packet stream out
   output logic                    access_out,
   output logic [`DMA_PW-1:0]      packet_out,
   input  wire logic               wait_in
);

   // ################################################
   // internal nets, names match the sub-block ports
   // ################################################

   dma_count_t         count_reg, count_next;
   logic [`DMA_AW-1:0] srcaddr_reg, dstaddr_reg;
   logic [`DMA_AW-1:0] srcaddr_next, dstaddr_next;
   dma_half_t          inner_start;
   dma_state_e         state;
   logic               update2d;
   logic               beat;
   logic               write_in, write_out;
   logic [1:0]         datamode_in, datamode_out;
   logic [4:0]         ctrlmode_in, ctrlmode_out;
   logic [`DMA_AW-1:0] dstaddr_in, dstaddr_out;
   emesh_payload_u     payload_in, payload_out;
   logic [`DMA_PW-1:0] packet;

   dma_seq      u_seq (.*);                       // registers and loop control
   emesh_decode u_decode (.*);                    // slave packet fields
   dma_datapath u_datapath (.*);                  // stepping, mux, output register
   emesh_encode u_encode (.*);                    // fields back into a packet

endmodule

`default_nettype wire

// ==== rtl/dma_pkg.sv ====
// dma sequencer state and transfer count types
`default_nettype none

`include "dma_cfg.svh"

package dma_pkg;

   typedef enum logic [1:0] {
      ST_IDLE,                         // waiting for start
      ST_RUN,                          // beats flowing
      ST_LAST                          // done cycle after the final beat
   } dma_state_e;

   typedef logic [`DMA_CW-1:0] dma_half_t;

   // outer loop in the upper half
   typedef struct packed {
      dma_half_t outer;
      dma_half_t inner;
   } dma_count_t;

endpackage

`default_nettype wire

// ==== rtl/dma_seq.sv ====
// dma sequencer, holds transfer registers and runs the 2d beat loop
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_seq
   import dma_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               arst_n,
   input  wire logic               start,
   input  wire logic               master_mode,
   input  wire logic               access_in,
   input  wire logic               wait_in,
   input  wire dma_count_t         count,
   input  wire logic [`DMA_AW-1:0] srcaddr,
   input  wire logic [`DMA_AW-1:0] dstaddr,
   input  wire dma_count_t         count_next,
   input  wire logic [`DMA_AW-1:0] srcaddr_next,
   input  wire logic [`DMA_AW-1:0] dstaddr_next,
   output dma_count_t              count_reg,
   output logic [`DMA_AW-1:0]      srcaddr_reg,
   output logic [`DMA_AW-1:0]      dstaddr_reg,
   output dma_half_t               inner_start,
   output logic                    update2d,
   output logic                    beat,
   output logic                    busy,
   output logic                    done,
   output dma_state_e              state
);

   dma_state_e state_next;
   logic       load;
   logic       last_beat;

   // ################################################
   // beat and loop decisions
   // ################################################

   assign busy = (state == ST_RUN);
   assign done = (state == ST_LAST);              // one cycle, busy already low
   assign load = start && !busy;                  // start while running is dropped

   // slave beats need an incoming packet
   assign beat = busy && !wait_in && (master_mode || access_in);

   assign update2d  = (count_reg.inner == dma_half_t'(1)) &&
                      (count_reg.outer > dma_half_t'(1));
   assign last_beat = beat && (count_reg.outer == dma_half_t'(1)) &&
                      (count_reg.inner == dma_half_t'(1));

   always_comb begin
      state_next = state;
      case (state)
         ST_IDLE, ST_LAST: state_next = load ? ST_RUN : ST_IDLE;
         ST_RUN:           if (last_beat) state_next = ST_LAST;
         default:          state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) state <= ST_IDLE;
      else         state <= state_next;
   end

   // transfer registers
   always_ff @(posedge clk) begin
      if (load) begin
         count_reg   <= count;
         srcaddr_reg <= srcaddr;
         dstaddr_reg <= dstaddr;
         inner_start <= count.inner;              // reload value for each outer pass
      end else if (beat) begin
         count_reg   <= count_next;
         srcaddr_reg <= srcaddr_next;
         dstaddr_reg <= dstaddr_next;
      end
   end

   a_count_live: assert property (
      @(posedge clk) disable iff (!arst_n)
      busy |-> (count_reg != '0));

   a_done_pulse: assert property (
      @(posedge clk) disable iff (!arst_n)
      done |=> !done);

endmodule

`default_nettype wire

// ==== rtl/emesh_decode.sv ====
// emesh packet decoder, splits a packet into head fields and payload
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module emesh_decode
   import emesh_pkg::*;
(
   input  wire logic [`DMA_PW-1:0] packet_in,
   output logic                    write_in,
   output logic [1:0]              datamode_in,
   output logic [4:0]              ctrlmode_in,
   output logic [`DMA_AW-1:0]      dstaddr_in,
   output emesh_payload_u          payload_in
);

   emesh_ctrl_t head;

   // ################################################
   // field split
   // ################################################

   assign head = packet_in[39:0];           // low 40 bits are the head

   assign write_in    = head.write;
   assign datamode_in = head.datamode;
   assign ctrlmode_in = head.ctrlmode;
   assign dstaddr_in  = head.dstaddr;

   // both words above the head, caller picks the view
   assign payload_in = packet_in[`DMA_PW-1:40];

endmodule

`default_nettype wire

// ==== rtl/emesh_encode.sv ====
// emesh packet encoder, packs head fields and payload into one packet
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module emesh_encode
   import emesh_pkg::*;
(
   input  wire logic               write_out,
   input  wire logic [1:0]         datamode_out,
   input  wire logic [4:0]         ctrlmode_out,
   input  wire logic [`DMA_AW-1:0] dstaddr_out,
   input  wire emesh_payload_u     payload_out,
   output logic [`DMA_PW-1:0]      packet
);

   emesh_ctrl_t head;

   // ################################################
   // head build
   // ################################################

   assign head.write    = write_out;
   assign head.datamode = datamode_out;
   assign head.ctrlmode = ctrlmode_out;
   assign head.dstaddr  = dstaddr_out;

   // same layout as the decoder, payload on top
   assign packet = {payload_out, head};

endmodule

`default_nettype wire

// ==== rtl/emesh_pkg.sv ====
// emesh packet field types shared by the packet decoder and encoder
`default_nettype none

`include "dma_cfg.svh"

package emesh_pkg;

   // head of a packet, low 40 bits, write in bit 0
   typedef struct packed {
      logic [`DMA_AW-1:0] dstaddr;
      logic [4:0]         ctrlmode;
      logic [1:0]         datamode;
      logic               write;
   } emesh_ctrl_t;

   typedef struct packed {
      logic [`DMA_AW-1:0] data_hi;     // upper word of a 64 bit write
      logic [`DMA_AW-1:0] data;
   } emesh_wr_t;

   typedef struct packed {
      logic [`DMA_AW-1:0] retaddr;     // where the read response goes
      logic [`DMA_AW-1:0] rsvd;
   } emesh_rd_t;

   // upper 64 bits, meaning depends on the write bit
   typedef union packed {
      emesh_wr_t wr;
      emesh_rd_t rd;
   } emesh_payload_u;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the dma engine testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_engine \
   -f dma_engine.f -o tb_dma_engine > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_dma_engine > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi
if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0

// ==== tb/tb_dma_engine.sv ====
// testbench for the dma engine, master, slave, pushback and restart transfers
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module tb_dma_engine;

   logic               clk, arst_n, start, master_mode;
   logic [1:0]         datamode;
   logic [4:0]         ctrlmode;
   logic [31:0]        stride, count, srcaddr, dstaddr;
   logic               busy, done, access_in, wait_out, access_out, wait_in;
   logic [`DMA_PW-1:0] packet_in, packet_out;
   logic [`DMA_PW-1:0] exp_q[$];                  // expected packets, in order
   logic [`DMA_PW-1:0] got_q[$];                  // packets taken off the output
   integer             seed;
   int                 err_cnt, test_err, fail_tests, done_cnt;

   dma_engine dma_engine_inst (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // a packet leaves on an edge with access_out and no pushback
   always @(posedge clk) begin
      if (arst_n && access_out && !wait_in) got_q.push_back(packet_out);
      if (arst_n && done) done_cnt++;
   end

   function automatic logic [31:0] sext16(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   task automatic apply_reset;
      arst_n      = 1'b0;
      start       = 1'b0;
      master_mode = 1'b0;
      datamode    = '0;
      ctrlmode    = '0;
      {stride, count, srcaddr, dstaddr} = '0;
      access_in   = 1'b0;
      packet_in   = '0;
      wait_in     = 1'b0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      exp_q.delete();
      got_q.delete();
      done_cnt = 0;
   endtask

   task automatic start_xfer(input logic mm, input logic [31:0] cnt, input logic [31:0] str,
                             input logic [31:0] src, input logic [31:0] dst);
      master_mode = mm;
      datamode    = 2'($random(seed));
      ctrlmode    = 5'($random(seed));
      {count, stride, srcaddr, dstaddr} = {cnt, str, src, dst};
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   // read request k: dst and return address both step linearly per beat
   task automatic expect_reads(input int n);
      logic [31:0] d, s;
      for (int k = 0; k < n; k++) begin
         d = dstaddr + k * sext16(stride[31:16]);
         s = srcaddr + k * sext16(stride[15:0]);
         exp_q.push_back({s, 32'h0, d, ctrlmode, datamode, 1'b0});
      end
   endtask

   // flag is looked at first, so a level already present counts
   task automatic wait_flag(input string what, input bit want_done, output bit ok);
      ok = 1'b0;
      for (int t = 0; t < 200 && !ok; t++) begin
         ok = want_done ? done : (!access_out && !busy);
         if (!ok) @(negedge clk);
      end
      if (!ok) $display("timeout while waiting for %s", what);
   endtask

   // done, then the last packet drains, then the whole stream is compared
   task automatic finish_xfer;
      bit ok;
      wait_flag("done pulse", 1'b1, ok);
      if (ok) begin
         assert (busy === 1'b0) else begin
            $display("[ERROR] busy: got %h expected %h", busy, 1'b0);
            test_err++;
         end
         wait_flag("output drain", 1'b0, ok);
      end
      if (!ok) test_err++;
      assert (got_q.size() == exp_q.size()) else begin
         $display("[ERROR] access_out beats: got %h expected %h", got_q.size(), exp_q.size());
         test_err++;
      end
      for (int k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
         assert (got_q[k] === exp_q[k]) else begin
            $display("[ERROR] packet_out[%0d]: got %h expected %h", k, got_q[k], exp_q[k]);
            test_err++;
         end
      end
      assert (done_cnt == 1) else begin
         $display("[ERROR] done pulses: got %h expected %h", done_cnt, 1);
         test_err++;
      end
   endtask

   task automatic end_test(input string name);
      if (test_err == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, test_err);
         fail_tests++;
      end
      err_cnt += test_err;
      test_err = 0;
   endtask

   // ##################################################
   // directed tests
   // ##################################################

   task automatic test_master_1d;
      apply_reset();
      assert ({busy, done, access_out} === 3'b000) else begin
         $display("[ERROR] busy,done,access_out: got %h expected %h",
                  {busy, done, access_out}, 3'b000);
         test_err++;
      end
      start_xfer(1'b1, {16'd1, 16'd4}, {16'h0010, 16'h0004}, 32'h1000_0000, 32'h8000_0100);
      expect_reads(4);
      finish_xfer();
      end_test("test 1 master 1x4");
   endtask

   task automatic test_master_2d;
      apply_reset();
      start_xfer(1'b1, {16'd3, 16'd2}, {16'hfff0, 16'h0008}, 32'h2000_0000, 32'h9000_0000);
      expect_reads(6);                             // dst walks downward
      finish_xfer();
      end_test("test 2 master 3x2");
   endtask

   task automatic test_slave;
      logic [`DMA_PW-1:0] pkt;
      logic [31:0]        d;
      bit                 ok;
      int                 k;
      apply_reset();
      start_xfer(1'b0, {16'd2, 16'd3}, {16'h0020, 16'h0000}, 32'h0, 32'h4000_0000);
      k  = 0;
      ok = 1'b0;
      for (int t = 0; t < 200 && !ok; t++) begin
         pkt       = {$random(seed), $random(seed), $random(seed), 8'($random(seed))};
         pkt[0]    = 1'b1;                         // write packets only
         packet_in = pkt;
         access_in = busy && (($random(seed) & 3) != 0);   // random gaps
         if (access_in) begin
            d = dstaddr + k * sext16(stride[31:16]);
            exp_q.push_back({pkt[`DMA_PW-1:40], d, pkt[7:0]});
            k++;
         end
         @(negedge clk);
         ok = done;
      end
      access_in = 1'b0;
      if (!ok) begin
         $display("timeout while waiting for done in the slave stream");
         test_err++;
      end
      assert (k == 6) else begin
         $display("[ERROR] access_in beats: got %h expected %h", k, 6);
         test_err++;
      end
      finish_xfer();                               // done still high here
      end_test("test 3 slave 2x3");
   endtask

   task automatic test_pushback;
      logic [`DMA_PW-1:0] held;
      logic               held_acc;
      apply_reset();
      start_xfer(1'b1, {16'd1, 16'd8}, {16'h0004, 16'h0004}, 32'h3000_0000, 32'h5000_0000);
      expect_reads(8);
      repeat (2) @(negedge clk);                   // let a couple of packets out
      wait_in  = 1'b1;
      held     = packet_out;
      held_acc = access_out;
      for (int t = 0; t < 5; t++) begin
         @(negedge clk);
         assert (wait_out === 1'b1 && access_out === held_acc && packet_out === held)
         else begin
            $display("[ERROR] wait_out,access_out: got %h expected %h",
                     {wait_out, access_out}, {1'b1, held_acc});
            $display("[ERROR] packet_out: got %h expected %h", packet_out, held);
            test_err++;
         end
      end
      wait_in = 1'b0;
      finish_xfer();
      end_test("test 4 pushback");
   endtask

   task automatic test_restart;
      apply_reset();
      start_xfer(1'b1, {16'd1, 16'd3}, {16'h0008, 16'h0004}, 32'h6000_0000, 32'h7000_0000);
      expect_reads(3);
      {count, srcaddr, dstaddr} = {16'd2, 16'd7, 32'h0bad_0000, 32'h0bad_1000};
      start = 1'b1;                                // should be dropped, busy
      @(negedge clk);
      start = 1'b0;
      finish_xfer();
      end_test("test 5 start while busy");
   endtask

   initial begin
      seed       = 32'hf818ee76;
      err_cnt    = 0;
      test_err   = 0;
      fail_tests = 0;
      test_master_1d();
      test_master_2d();
      test_slave();
      test_pushback();
      test_restart();
      $display("tests 5, failed %0d, errors %0d", fail_tests, err_cnt);
      if (err_cnt == 0) $display("Simulation passed");
      else $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
